/* src/tlb_cfg_pkg.sv */
package tlb_cfg_pkg;

    // table geometry
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = $clog2(TLB_NUM);

    // virtual side, vppn covers va[31:13]
    localparam int VPPN_W    = 19;
    // low vppn bits that a 4 MB page ignores
    localparam int VPPN_LO_W = 10;
    localparam int ASID_W    = 10;

    // physical side and page attributes
    localparam int PPN_W = 20;
    localparam int PLV_W = 2;
    localparam int MAT_W = 2;

    // page size encodings as seen on the ps field
    localparam int PS_W = 6;
    localparam logic [PS_W-1:0] PS_4K = 6'd12;
    localparam logic [PS_W-1:0] PS_4M = 6'd22;

endpackage

/* src/tlb_types_pkg.sv */
package tlb_types_pkg;

    import tlb_cfg_pkg::*;

    // attributes of one page of the even/odd pair
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [PLV_W-1:0] plv;
        logic [MAT_W-1:0] mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    // stored entry, page size kept as a single flag
    typedef struct packed {
        logic              e;
        logic              ps4m;
        logic [VPPN_W-1:0] vppn;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              va_bit12;
        logic [ASID_W-1:0] asid;
    } tlb_search_req_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic [PPN_W-1:0]     ppn;
        logic [PS_W-1:0]      ps;
        logic [PLV_W-1:0]     plv;
        logic [MAT_W-1:0]     mat;
        logic                 d;
        logic                 v;
    } tlb_search_rsp_t;

    // payload of the write and fill instructions
    typedef struct packed {
        logic [TLB_IDX_W-1:0] index;
        logic                 e;
        logic [PS_W-1:0]      ps;
        logic [VPPN_W-1:0]    vppn;
        logic [ASID_W-1:0]    asid;
        logic                 g;
        tlb_page_t            page0;
        tlb_page_t            page1;
    } tlb_write_t;

    // invtlb op codes, 7 and up select nothing
    typedef enum logic [4:0] {
        INV_ALL0         = 5'd0,
        INV_ALL1         = 5'd1,
        INV_GLOBAL       = 5'd2,
        INV_NONGLOBAL    = 5'd3,
        INV_ASID         = 5'd4,
        INV_ASID_VA      = 5'd5,
        INV_ASID_OR_G_VA = 5'd6
    } tlb_inv_op_e;

    // virtual page compare without the asid term
    // a 4 MB entry only looks at the upper vppn bits
    function automatic logic tlb_va_match(tlb_entry_t ent, logic [VPPN_W-1:0] vppn);
        logic hi_eq;
        logic lo_eq;
        hi_eq = (ent.vppn[VPPN_W-1:VPPN_LO_W] == vppn[VPPN_W-1:VPPN_LO_W]);
        lo_eq = (ent.vppn[VPPN_LO_W-1:0] == vppn[VPPN_LO_W-1:0]);
        return hi_eq && (ent.ps4m || lo_eq);
    endfunction

endpackage

/* src/tlb_inv_match.sv */
`timescale 1ns/1ps

module tlb_inv_match (
    input  logic                           invtlb_valid,
    input  tlb_types_pkg::tlb_inv_op_e     invtlb_op,
    input  tlb_types_pkg::tlb_search_req_t operand,
    input  tlb_types_pkg::tlb_entry_t      entries [tlb_cfg_pkg::TLB_NUM],
    output logic [tlb_cfg_pkg::TLB_NUM-1:0] inv_clear
);

    import tlb_cfg_pkg::*;
    import tlb_types_pkg::*;

    // per-entry terms the op codes are built from
    logic [TLB_NUM-1:0] is_global;
    logic [TLB_NUM-1:0] asid_eq;
    logic [TLB_NUM-1:0] va_eq;
    logic [TLB_NUM-1:0] op_sel;

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            is_global[i] = entries[i].g;
            asid_eq[i]   = (entries[i].asid == operand.asid);
            va_eq[i]     = tlb_va_match(entries[i], operand.vppn);
        end
    end

    // exist bit is not a term here, clearing an empty slot is harmless
    always_comb begin
        case (invtlb_op)
            INV_ALL0, INV_ALL1: begin
                op_sel = '1;
            end
            INV_GLOBAL: begin
                op_sel = is_global;
            end
            INV_NONGLOBAL: begin
                op_sel = ~is_global;
            end
            INV_ASID: begin
                op_sel = ~is_global & asid_eq;
            end
            INV_ASID_VA: begin
                op_sel = ~is_global & asid_eq & va_eq;
            end
            INV_ASID_OR_G_VA: begin
                op_sel = (is_global | asid_eq) & va_eq;
            end
            default: begin
                op_sel = '0;
            end
        endcase
    end

    assign inv_clear = invtlb_valid ? op_sel : '0;

    // an unknown op code would clear an arbitrary set of entries in the array
    always_comb begin
        if (invtlb_valid) begin
            a_op_known: assert #0 (!$isunknown(invtlb_op))
                else $error("invtlb_op unknown while invtlb_valid is high");
        end
    end

endmodule

/* src/tlb_entry_array.sv */
`timescale 1ns/1ps

module tlb_entry_array (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  tlb_types_pkg::tlb_write_t       w,
    input  logic [tlb_cfg_pkg::TLB_NUM-1:0] inv_clear,
    output tlb_types_pkg::tlb_entry_t       entries [tlb_cfg_pkg::TLB_NUM]
);

    import tlb_cfg_pkg::*;
    import tlb_types_pkg::*;

    tlb_entry_t store [TLB_NUM];

    // reset and invalidate only touch the exist bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                store[i].e <= 1'b0;
            end
        end else begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (inv_clear[i]) begin
                    store[i].e <= 1'b0;
                end
            end
            // write after the clear so the written e wins on the same index
            // ps collapses to a 4 MB flag
            if (we) begin
                store[w.index] <= '{
                    e:     w.e,
                    ps4m:  (w.ps == PS_4M),
                    vppn:  w.vppn,
                    asid:  w.asid,
                    g:     w.g,
                    page0: w.page0,
                    page1: w.page1
                };
            end
        end
    end

    assign entries = store;

    // a write with an unknown index would corrupt the whole table
    a_windex_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(w.index)
    ) else $error("w.index unknown on a write");

endmodule

/* src/tlb_search_port.sv */
`timescale 1ns/1ps

module tlb_search_port (
    input  tlb_types_pkg::tlb_search_req_t req,
    input  tlb_types_pkg::tlb_entry_t      entries [tlb_cfg_pkg::TLB_NUM],
    output tlb_types_pkg::tlb_search_rsp_t rsp
);

    import tlb_cfg_pkg::*;
    import tlb_types_pkg::*;

    logic [TLB_NUM-1:0]   match;
    logic [TLB_IDX_W-1:0] hit_idx;
    tlb_entry_t           hit_ent;
    tlb_page_t            hit_page;
    logic                 pick_odd;

    // associative compare against every entry
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            match[i] = entries[i].e
                    && tlb_va_match(entries[i], req.vppn)
                    && (entries[i].g || entries[i].asid == req.asid);
        end
    end

    // or of the matching indices, only valid while match is one-hot
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (match[i]) begin
                hit_idx = hit_idx | TLB_IDX_W'(i);
            end
        end
    end

    assign hit_ent = entries[hit_idx];

    // odd page bit is va[12] for 4 KB and va[22] for 4 MB
    // va[22] sits at vppn bit 9
    assign pick_odd = hit_ent.ps4m ? req.vppn[VPPN_LO_W-1] : req.va_bit12;
    assign hit_page = pick_odd ? hit_ent.page1 : hit_ent.page0;

    always_comb begin
        rsp.found = |match;
        rsp.index = hit_idx;
        rsp.ppn   = hit_page.ppn;
        rsp.ps    = hit_ent.ps4m ? PS_4M : PS_4K;
        rsp.plv   = hit_page.plv;
        rsp.mat   = hit_page.mat;
        rsp.d     = hit_page.d;
        rsp.v     = hit_page.v;
    end

    // overlapping entries would make index a blend of two slots
    always_comb begin
        if (!$isunknown(match)) begin
            a_match_onehot: assert #0 ($onehot0(match))
                else $error("multiple TLB entries match one search");
        end
    end

endmodule

/* src/tlb_top.sv */
`timescale 1ns/1ps

module tlb_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  tlb_types_pkg::tlb_search_req_t s0_req,
    input  tlb_types_pkg::tlb_search_req_t s1_req,
    input  logic                           we,
    input  tlb_types_pkg::tlb_write_t      w,
    input  logic                           invtlb_valid,
    input  tlb_types_pkg::tlb_inv_op_e     invtlb_op,
    output tlb_types_pkg::tlb_search_rsp_t s0_rsp,
    output tlb_types_pkg::tlb_search_rsp_t s1_rsp
);

    import tlb_cfg_pkg::*;
    import tlb_types_pkg::*;

    tlb_entry_t         entries [TLB_NUM];
    logic [TLB_NUM-1:0] inv_clear;

    // invalidate operands ride on the memory-access search port
    tlb_inv_match u_inv_match (
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .operand      (s1_req),
        .entries      (entries),
        .inv_clear    (inv_clear)
    );

    tlb_entry_array u_entry_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (we),
        .w         (w),
        .inv_clear (inv_clear),
        .entries   (entries)
    );

    // instruction fetch
    tlb_search_port u_search0 (
        .req     (s0_req),
        .entries (entries),
        .rsp     (s0_rsp)
    );

    // memory access
    tlb_search_port u_search1 (
        .req     (s1_req),
        .entries (entries),
        .rsp     (s1_rsp)
    );

endmodule

/* verif/tlb_tb_model.svh */
`ifndef TLB_TB_MODEL_SVH
`define TLB_TB_MODEL_SVH

// shadow copy of the entry table, updated at the same edges as the DUT
tlb_entry_t shadow [TLB_NUM];

// same virtual pages, asid left out
function automatic logic va_equal(tlb_entry_t ent, logic [VPPN_W-1:0] vppn);
    if (ent.vppn[VPPN_W-1:VPPN_LO_W] != vppn[VPPN_W-1:VPPN_LO_W]) begin
        return 1'b0;
    end
    // 4 MB pages ignore the low vppn bits
    return ent.ps4m || (ent.vppn[VPPN_LO_W-1:0] == vppn[VPPN_LO_W-1:0]);
endfunction

function automatic tlb_search_rsp_t ref_search(tlb_search_req_t req);
    tlb_search_rsp_t rsp;
    tlb_page_t       pg;
    logic            odd;
    rsp = '0;
    for (int i = 0; i < TLB_NUM; i++) begin
        if (shadow[i].e && va_equal(shadow[i], req.vppn)
                && (shadow[i].g || shadow[i].asid == req.asid)) begin
            // va[22] for 4 MB, va[12] for 4 KB
            odd       = shadow[i].ps4m ? req.vppn[VPPN_LO_W-1] : req.va_bit12;
            pg        = odd ? shadow[i].page1 : shadow[i].page0;
            rsp.found = 1'b1;
            rsp.index = TLB_IDX_W'(i);
            rsp.ppn   = pg.ppn;
            rsp.ps    = shadow[i].ps4m ? 6'd22 : 6'd12;
            rsp.plv   = pg.plv;
            rsp.mat   = pg.mat;
            rsp.d     = pg.d;
            rsp.v     = pg.v;
        end
    end
    return rsp;
endfunction

function automatic logic [TLB_NUM-1:0] ref_inv_select(logic [4:0] op, tlb_search_req_t opnd);
    logic [TLB_NUM-1:0] sel;
    logic               glb;
    logic               same_asid;
    logic               same_va;
    for (int i = 0; i < TLB_NUM; i++) begin
        glb       = shadow[i].g;
        same_asid = (shadow[i].asid == opnd.asid);
        same_va   = va_equal(shadow[i], opnd.vppn);
        case (op)
            5'd0, 5'd1: sel[i] = 1'b1;
            5'd2:       sel[i] = glb;
            5'd3:       sel[i] = !glb;
            5'd4:       sel[i] = !glb && same_asid;
            5'd5:       sel[i] = !glb && same_asid && same_va;
            5'd6:       sel[i] = (glb || same_asid) && same_va;
            default:    sel[i] = 1'b0;
        endcase
    end
    return sel;
endfunction

function automatic void model_reset();
    for (int i = 0; i < TLB_NUM; i++) begin
        shadow[i].e = 1'b0;
    end
endfunction

function automatic void model_inv(logic [4:0] op, tlb_search_req_t opnd);
    logic [TLB_NUM-1:0] sel;
    sel = ref_inv_select(op, opnd);
    for (int i = 0; i < TLB_NUM; i++) begin
        if (sel[i]) begin
            shadow[i].e = 1'b0;
        end
    end
endfunction

// called after model_inv so a write to the same slot wins
function automatic void model_write(tlb_write_t wr);
    shadow[wr.index] = '{e: wr.e, ps4m: (wr.ps == 6'd22), vppn: wr.vppn, asid: wr.asid,
                         g: wr.g, page0: wr.page0, page1: wr.page1};
endfunction

`endif

/* verif/tb_tlb_top.sv */
`timescale 1ns/1ps

module tb_tlb_top;

    import tlb_cfg_pkg::*;
    import tlb_types_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int SEED       = 43817;
    localparam int WAIT_LIMIT = 20;
    localparam int TAG_RAND_W = VPPN_W - VPPN_LO_W - TLB_IDX_W;

    logic            clk;
    logic            rst_n;
    tlb_search_req_t s0_req;
    tlb_search_req_t s1_req;
    logic            we;
    tlb_write_t      w;
    logic            invtlb_valid;
    tlb_inv_op_e     invtlb_op;
    tlb_search_rsp_t s0_rsp;
    tlb_search_rsp_t s1_rsp;

    int unsigned err_cnt;
    int unsigned cmp_cnt;

    `include "tlb_tb_model.svh"

    tlb_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .s0_req       (s0_req),
        .s1_req       (s1_req),
        .we           (we),
        .w            (w),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .s0_rsp       (s0_rsp),
        .s1_rsp       (s1_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // model samples the same inputs at the same edge
    always @(posedge clk) begin
        if (!rst_n) begin
            model_reset();
        end else begin
            if (invtlb_valid) begin
                model_inv(invtlb_op, s1_req);
            end
            if (we) begin
                model_write(w);
            end
        end
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %s expected %0h got %0h", name, exp, got);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_rsp(input string name, input tlb_search_rsp_t exp,
                               input tlb_search_rsp_t got);
        check({name, ".found"}, exp.found, got.found);
        // remaining fields only mean something on a hit
        if (exp.found) begin
            check({name, ".index"}, exp.index, got.index);
            check({name, ".ppn"}, exp.ppn, got.ppn);
            check({name, ".ps"}, exp.ps, got.ps);
            check({name, ".plv"}, exp.plv, got.plv);
            check({name, ".mat"}, exp.mat, got.mat);
            check({name, ".d"}, exp.d, got.d);
            check({name, ".v"}, exp.v, got.v);
        end
    endtask

    // responses settle mid-cycle well clear of both edges
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            compare_rsp("s0_rsp", ref_search(s0_req), s0_rsp);
            compare_rsp("s1_rsp", ref_search(s1_req), s1_rsp);
            cmp_cnt++;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_compared();
        int unsigned start;
        int          n;
        start = cmp_cnt;
        n     = 0;
        while (cmp_cnt == start) begin
            if (n >= WAIT_LIMIT) begin
                $display("timeout: no response compare within %0d cycles", WAIT_LIMIT);
                $display("*** FAILED ***");
                $fatal(1, "compare process stalled");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // mode 0 gives 4 KB, 1 gives 4 MB, 2 picks either
    function automatic tlb_write_t random_entry(int idx, int mode);
        tlb_write_t wr;
        logic       big;
        wr = '0;
        if (mode == 2) begin
            big = $urandom_range(0, 1);
        end else begin
            big = (mode == 1);
        end
        wr.index = TLB_IDX_W'(idx);
        wr.e     = 1'b1;
        wr.ps    = big ? 6'd22 : 6'd12;
        // slot number sits in the upper vppn bits so slots never overlap
        wr.vppn  = {TAG_RAND_W'($urandom), TLB_IDX_W'(idx), VPPN_LO_W'($urandom)};
        // few asids so asid based invalidates hit several slots
        wr.asid  = ASID_W'(10'h010 + $urandom_range(0, 3));
        wr.g     = ($urandom_range(0, 3) == 0);
        wr.page0 = 26'($urandom);
        wr.page1 = 26'($urandom);
        return wr;
    endfunction

    function automatic tlb_search_req_t request_for(int idx, bit wrong_asid);
        tlb_search_req_t req;
        req.vppn = shadow[idx].vppn;
        if (shadow[idx].ps4m) begin
            req.vppn[VPPN_LO_W-1:0] = VPPN_LO_W'($urandom);
        end
        req.va_bit12 = $urandom_range(0, 1);
        req.asid     = wrong_asid ? (shadow[idx].asid ^ 10'h200) : shadow[idx].asid;
        return req;
    endfunction

    task automatic write_entry(input tlb_write_t wr);
        we = 1'b1;
        w  = wr;
        next_cycle();
        we = 1'b0;
    endtask

    task automatic fill_table(input int mode);
        for (int i = 0; i < TLB_NUM; i++) begin
            write_entry(random_entry(i, mode));
        end
    endtask

    task automatic invalidate(input logic [4:0] op, input tlb_search_req_t opnd);
        invtlb_valid = 1'b1;
        invtlb_op    = tlb_inv_op_e'(op);
        s1_req       = opnd;
        next_cycle();
        invtlb_valid = 1'b0;
    endtask

    // both ports probe different slots in the same cycle
    task automatic search_all(input bit wrong_asid);
        for (int i = 0; i < TLB_NUM; i++) begin
            s0_req = request_for(i, wrong_asid);
            s1_req = request_for((i + 5) % TLB_NUM, wrong_asid);
            wait_compared();
        end
    endtask

    initial begin
        tlb_search_req_t opnd;
        tlb_write_t      wr;
        int              tgt;
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        s0_req       = '0;
        s1_req       = '0;
        we           = 1'b0;
        w            = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = INV_ALL0;
        err_cnt      = 0;
        cmp_cnt      = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // empty table after reset
        repeat (8) begin
            s0_req = 30'($urandom);
            s1_req = 30'($urandom);
            wait_compared();
        end

        // 4 KB then 4 MB entries with right and wrong asid
        fill_table(0);
        search_all(0);
        search_all(1);
        fill_table(1);
        search_all(0);
        search_all(1);

        // every invalidate op with the operand taken from one live slot
        for (int op = 0; op < 8; op++) begin
            fill_table(2);
            tgt  = $urandom_range(0, TLB_NUM - 1);
            opnd = request_for(tgt, 0);
            invalidate(5'(op), opnd);
            search_all(0);
        end

        // write with e=0 over the live slot 5 drops it
        wr      = random_entry(5, 0);
        wr.e    = 1'b0;
        wr.vppn = shadow[5].vppn;
        wr.asid = shadow[5].asid;
        write_entry(wr);
        s0_req = request_for(5, 0);
        s1_req = s0_req;
        wait_compared();
        check("s0_rsp.found", 0, s0_rsp.found);

        // write and clear-all in one cycle keep slot 9
        fill_table(2);
        wr = random_entry(9, 2);
        we = 1'b1;
        w  = wr;
        invalidate(5'd0, request_for(0, 0));
        we = 1'b0;
        search_all(0);
        s0_req = request_for(9, 0);
        wait_compared();
        check("s0_rsp.found", 1, s0_rsp.found);

        // search held across the write edge sees the new slot next cycle
        wr              = random_entry(3, 0);
        s1_req.vppn     = wr.vppn;
        s1_req.va_bit12 = 1'b1;
        s1_req.asid     = wr.asid;
        s0_req          = s1_req;
        we              = 1'b1;
        w               = wr;
        next_cycle();
        we = 1'b0;
        wait_compared();
        check("s1_rsp.found", 1, s1_rsp.found);
        check("s1_rsp.index", 3, s1_rsp.index);
        check("s1_rsp.ppn", wr.page1.ppn, s1_rsp.ppn);

        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verif
src/tlb_cfg_pkg.sv
src/tlb_types_pkg.sv
src/tlb_inv_match.sv
src/tlb_entry_array.sv
src/tlb_search_port.sv
src/tlb_top.sv
verif/tb_tlb_top.sv
